/* rv_int_consts.svh */
/* width and size constants for the rv32i integer path
   include in any file that sizes data, pc or register addresses */
`ifndef RV_INT_CONSTS_SVH
`define RV_INT_CONSTS_SVH

// data and pc width, one word
`define XLEN 32

// architectural register file
`define REG_COUNT 32
`define REG_ADDR_BITS 5

// shifts only look at the low bits of operand b
`define SHAMT_BITS 5

`endif

/* rv_int_pkg.sv */
/* shared enum types of the rv32i integer path
   decoder, executor and alu import this package */
`default_nettype none

package rv_int_pkg;

	// major opcodes handled by the unit, instr[6:0]
	typedef enum logic [6:0] {
		lui    = 7'b0110111,
		auipc  = 7'b0010111,
		jal    = 7'b1101111,
		jalr   = 7'b1100111,
		branch = 7'b1100011,
		op_imm = 7'b0010011,
		op     = 7'b0110011
	} opcode_t;

	// alu operation codes, same numbering as the original alu block
	typedef enum logic [3:0] {
		alu_add    = 4'b0000,
		alu_sub    = 4'b0001,
		alu_sll    = 4'b0010,
		alu_slt    = 4'b0011,
		alu_sltu   = 4'b0100,
		alu_xor    = 4'b0101,
		alu_srl    = 4'b0110,
		alu_sra    = 4'b0111,
		alu_or     = 4'b1000,
		alu_and    = 4'b1001,
		alu_pass_b = 4'b1010
	} alu_op_t;

	// how the executor turns the alu outcome into a pc decision
	typedef enum logic [3:0] {
		br_none,
		br_eq,
		br_ne,
		br_lt,
		br_ge,
		br_ltu,
		br_geu,
		br_jump,
		br_jump_reg
	} branch_cond_t;

endpackage

`default_nettype wire

/* rv_reg_file.sv */
/* 32 x 32 register file, two combinational read ports and one write port
   a write in the same cycle as a read of that address is passed straight through */
`timescale 1ns/1ps
`default_nettype none
`include "rv_int_consts.svh"

module rv_reg_file (
	input  wire                       clk,
	input  wire                       reset,
	input  wire [`REG_ADDR_BITS-1:0]  rs1_addr,
	input  wire [`REG_ADDR_BITS-1:0]  rs2_addr,
	output logic [`XLEN-1:0]          rs1_data,
	output logic [`XLEN-1:0]          rs2_data,
	input  wire                       wr_en,
	input  wire [`REG_ADDR_BITS-1:0]  wr_addr,
	input  wire [`XLEN-1:0]           wr_data
);

	logic [`XLEN-1:0] regs [`REG_COUNT];

	// x0 is never stored, so it keeps reading zero
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// read ports with write-through
	always_comb begin
		if (rs1_addr == '0)
			rs1_data = '0;
		else if (wr_en && wr_addr == rs1_addr)
			rs1_data = wr_data;
		else
			rs1_data = regs[rs1_addr];

		if (rs2_addr == '0)
			rs2_data = '0;
		else if (wr_en && wr_addr == rs2_addr)
			rs2_data = wr_data;
		else
			rs2_data = regs[rs2_addr];
	end

endmodule

`default_nettype wire

/* rv_decoder.sv */
/* decode stage: splits the instruction, builds the immediate, reads the operands
   and registers it all for the executor on the edge that samples instr_valid */
`timescale 1ns/1ps
`default_nettype none
`include "rv_int_consts.svh"

module rv_decoder
	import rv_int_pkg::*;
(
	input  wire                       clk,
	input  wire                       reset,
	input  wire                       instr_valid,
	input  wire [31:0]                instr,
	input  wire [`XLEN-1:0]           pc,
	output logic [`REG_ADDR_BITS-1:0] rs1_addr,
	output logic [`REG_ADDR_BITS-1:0] rs2_addr,
	input  wire [`XLEN-1:0]           rs1_data,
	input  wire [`XLEN-1:0]           rs2_data,
	output logic                      d_valid,
	output logic [`REG_ADDR_BITS-1:0] d_rs1,
	output logic [`REG_ADDR_BITS-1:0] d_rs2,
	output logic [`REG_ADDR_BITS-1:0] d_rd,
	output logic [`XLEN-1:0]          d_rs1_data,
	output logic [`XLEN-1:0]          d_rs2_data,
	output logic [`XLEN-1:0]          d_imm,
	output logic [`XLEN-1:0]          d_pc,
	output alu_op_t                   d_alu_op,
	output logic                      d_use_imm,
	output logic                      d_use_pc,
	output branch_cond_t              d_branch,
	output logic                      d_illegal
);

	opcode_t          opcode;
	logic [2:0]       funct3;
	logic [6:0]       funct7;
	logic [`XLEN-1:0] imm_i;
	logic [`XLEN-1:0] imm_u;
	logic [`XLEN-1:0] imm_b;
	logic [`XLEN-1:0] imm_j;

	// decoded fields before the stage register
	logic [`REG_ADDR_BITS-1:0] rd;
	logic [`XLEN-1:0]          imm;
	alu_op_t                   alu_op;
	logic                      use_imm;
	logic                      use_pc;
	branch_cond_t              br;
	logic                      bad;

	assign opcode   = opcode_t'(instr[6:0]);
	assign funct3   = instr[14:12];
	assign funct7   = instr[31:25];
	assign rs1_addr = instr[19:15];
	assign rs2_addr = instr[24:20];

	// immediates, all sign extended from instr[31]
	assign imm_i = {{(`XLEN-12){instr[31]}}, instr[31:20]};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_b = {{(`XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
		instr[11:8], 1'b0};
	assign imm_j = {{(`XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20],
		instr[30:21], 1'b0};

	always_comb begin
		rd      = instr[11:7];
		imm     = imm_i;
		alu_op  = alu_add;
		use_imm = 1'b1;
		use_pc  = 1'b0;
		br      = br_none;
		bad     = 1'b0;
		case (opcode)
			lui: begin
				imm    = imm_u;
				alu_op = alu_pass_b;
			end
			auipc: begin
				imm    = imm_u;
				use_pc = 1'b1;
			end
			// jal target comes out of the alu as pc + imm
			jal: begin
				imm    = imm_j;
				use_pc = 1'b1;
				br     = br_jump;
			end
			// jalr target is rs1 + imm
			jalr: begin
				br  = br_jump_reg;
				bad = (funct3 != 3'b000);
			end
			// compare rs1 against rs2, target built in the executor
			branch: begin
				rd      = '0;
				imm     = imm_b;
				use_imm = 1'b0;
				case (funct3)
					3'b000: begin
						alu_op = alu_sub;
						br     = br_eq;
					end
					3'b001: begin
						alu_op = alu_sub;
						br     = br_ne;
					end
					3'b100: begin
						alu_op = alu_slt;
						br     = br_lt;
					end
					3'b101: begin
						alu_op = alu_slt;
						br     = br_ge;
					end
					3'b110: begin
						alu_op = alu_sltu;
						br     = br_ltu;
					end
					3'b111: begin
						alu_op = alu_sltu;
						br     = br_geu;
					end
					default: bad = 1'b1;
				endcase
			end
			op_imm: begin
				case (funct3)
					3'b000: alu_op = alu_add;
					3'b010: alu_op = alu_slt;
					3'b011: alu_op = alu_sltu;
					3'b100: alu_op = alu_xor;
					3'b110: alu_op = alu_or;
					3'b111: alu_op = alu_and;
					3'b001: begin
						alu_op = alu_sll;
						bad    = (funct7 != 7'b0000000);
					end
					// imm[10] picks the arithmetic shift
					default: begin
						alu_op = (funct7[5]) ? alu_sra : alu_srl;
						bad    = (funct7 != 7'b0000000 && funct7 != 7'b0100000);
					end
				endcase
			end
			op: begin
				use_imm = 1'b0;
				if (funct7 == 7'b0000000) begin
					case (funct3)
						3'b000: alu_op = alu_add;
						3'b001: alu_op = alu_sll;
						3'b010: alu_op = alu_slt;
						3'b011: alu_op = alu_sltu;
						3'b100: alu_op = alu_xor;
						3'b101: alu_op = alu_srl;
						3'b110: alu_op = alu_or;
						default: alu_op = alu_and;
					endcase
				end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
					alu_op = alu_sub;
				end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
					alu_op = alu_sra;
				end else begin
					bad = 1'b1;
				end
			end
			default: bad = 1'b1;
		endcase
		// illegal instructions write nothing and never redirect
		if (bad) begin
			rd = '0;
			br = br_none;
		end
	end

	// control state
	always_ff @(posedge clk) begin
		if (reset) begin
			d_valid   <= 1'b0;
			d_illegal <= 1'b0;
		end else begin
			d_valid   <= instr_valid;
			d_illegal <= instr_valid & bad;
		end
	end

	// payload, loaded every cycle and qualified by d_valid downstream
	always_ff @(posedge clk) begin
		d_rs1      <= rs1_addr;
		d_rs2      <= rs2_addr;
		d_rd       <= rd;
		d_rs1_data <= rs1_data;
		d_rs2_data <= rs2_data;
		d_imm      <= imm;
		d_pc       <= pc;
		d_alu_op   <= alu_op;
		d_use_imm  <= use_imm;
		d_use_pc   <= use_pc;
		d_branch   <= br;
	end

endmodule

`default_nettype wire

/* rv_alu.sv */
/* combinational alu for the rv32i integer ops
   shifts use the low five bits of src2, slt/sltu give 0 or 1 */
`timescale 1ns/1ps
`default_nettype none
`include "rv_int_consts.svh"

module rv_alu
	import rv_int_pkg::*;
(
	input  wire [`XLEN-1:0]  src1,
	input  wire [`XLEN-1:0]  src2,
	input  alu_op_t          alu_control,
	output logic [`XLEN-1:0] result,
	output logic             zero
);

	logic signed [`XLEN-1:0] signed_a;
	logic signed [`XLEN-1:0] signed_b;
	logic [`SHAMT_BITS-1:0]  shamt;
	logic [`XLEN-1:0]        diff;

	assign signed_a = src1;
	assign signed_b = src2;
	assign shamt    = src2[`SHAMT_BITS-1:0];

	// shared subtractor for sub and the equality compare
	assign diff = src1 - src2;

	always_comb begin
		case (alu_control)
			alu_add:    result = src1 + src2;
			alu_sub:    result = diff;
			alu_sll:    result = src1 << shamt;
			alu_slt:    result = {{(`XLEN-1){1'b0}}, signed_a < signed_b};
			alu_sltu:   result = {{(`XLEN-1){1'b0}}, src1 < src2};
			alu_xor:    result = src1 ^ src2;
			alu_srl:    result = src1 >> shamt;
			// sign bit fills from the left
			alu_sra:    result = signed_a >>> shamt;
			alu_or:     result = src1 | src2;
			alu_and:    result = src1 & src2;
			alu_pass_b: result = src2;
			default:    result = '0;
		endcase
	end

	// beq/bne read this after a sub
	assign zero = (result == '0);

endmodule

`default_nettype wire

/* rv_executor.sv */
/* execute stage: forwards operands, runs the alu, resolves branches and jumps
   and registers the outcome for the writeback stage */
`timescale 1ns/1ps
`default_nettype none
`include "rv_int_consts.svh"

module rv_executor
	import rv_int_pkg::*;
(
	input  wire                       clk,
	input  wire                       reset,
	input  wire                       d_valid,
	input  wire [`REG_ADDR_BITS-1:0]  d_rs1,
	input  wire [`REG_ADDR_BITS-1:0]  d_rs2,
	input  wire [`REG_ADDR_BITS-1:0]  d_rd,
	input  wire [`XLEN-1:0]           d_rs1_data,
	input  wire [`XLEN-1:0]           d_rs2_data,
	input  wire [`XLEN-1:0]           d_imm,
	input  wire [`XLEN-1:0]           d_pc,
	input  alu_op_t                   d_alu_op,
	input  wire                       d_use_imm,
	input  wire                       d_use_pc,
	input  branch_cond_t              d_branch,
	input  wire                       d_illegal,
	input  wire                       wb_valid,
	input  wire [`REG_ADDR_BITS-1:0]  wb_rd,
	input  wire [`XLEN-1:0]           wb_data,
	output logic                      e_valid,
	output logic [`REG_ADDR_BITS-1:0] e_rd,
	output logic [`XLEN-1:0]          e_result,
	output logic [`XLEN-1:0]          e_next_pc,
	output logic                      e_taken,
	output logic                      e_illegal
);

	logic [`XLEN-1:0] rs1_val;
	logic [`XLEN-1:0] rs2_val;
	logic [`XLEN-1:0] src1;
	logic [`XLEN-1:0] src2;
	logic [`XLEN-1:0] alu_result;
	logic             alu_zero;
	logic [`XLEN-1:0] pc_plus4;
	logic [`XLEN-1:0] target;
	logic             taken;
	logic             is_jump;
	logic             fwd_e1;
	logic             fwd_e2;
	logic             fwd_w1;
	logic             fwd_w2;

	// newest value first: previous instruction, then the one before it
	// rd is zero for x0, branches and illegal ops, so those never match
	assign fwd_e1 = e_valid && e_rd != '0 && e_rd == d_rs1;
	assign fwd_e2 = e_valid && e_rd != '0 && e_rd == d_rs2;
	assign fwd_w1 = wb_valid && wb_rd != '0 && wb_rd == d_rs1;
	assign fwd_w2 = wb_valid && wb_rd != '0 && wb_rd == d_rs2;

	assign rs1_val = fwd_e1 ? e_result : (fwd_w1 ? wb_data : d_rs1_data);
	assign rs2_val = fwd_e2 ? e_result : (fwd_w2 ? wb_data : d_rs2_data);

	assign src1 = d_use_pc  ? d_pc  : rs1_val;
	assign src2 = d_use_imm ? d_imm : rs2_val;

	rv_alu u_alu (
		.src1        (src1),
		.src2        (src2),
		.alu_control (d_alu_op),
		.result      (alu_result),
		.zero        (alu_zero)
	);

	assign pc_plus4 = d_pc + `XLEN'd4;
	assign is_jump  = (d_branch == br_jump) || (d_branch == br_jump_reg);

	// jalr drops bit 0 of rs1 + imm, everything else targets pc + imm
	assign target = (d_branch == br_jump_reg) ? {alu_result[`XLEN-1:1], 1'b0}
		: d_pc + d_imm;

	always_comb begin
		case (d_branch)
			br_eq:       taken = alu_zero;
			br_ne:       taken = !alu_zero;
			br_lt:       taken = alu_result[0];
			br_ge:       taken = !alu_result[0];
			br_ltu:      taken = alu_result[0];
			br_geu:      taken = !alu_result[0];
			br_jump:     taken = 1'b1;
			br_jump_reg: taken = 1'b1;
			default:     taken = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			e_valid   <= 1'b0;
			e_taken   <= 1'b0;
			e_illegal <= 1'b0;
		end else begin
			e_valid   <= d_valid;
			e_taken   <= d_valid & taken;
			e_illegal <= d_valid & d_illegal;
		end
	end

	// jumps link pc + 4, conditional branches and illegal ops report zero
	always_ff @(posedge clk) begin
		e_rd      <= d_rd;
		e_next_pc <= taken ? target : pc_plus4;
		if (is_jump)
			e_result <= pc_plus4;
		else if (d_illegal || d_branch != br_none)
			e_result <= '0;
		else
			e_result <= alu_result;
	end

endmodule

`default_nettype wire

/* rv_writeback.sv */
/* result stage: registers the execute outcome onto the external outputs
   and drives the register file write port from those registers */
`timescale 1ns/1ps
`default_nettype none
`include "rv_int_consts.svh"

module rv_writeback (
	input  wire                       clk,
	input  wire                       reset,
	input  wire                       e_valid,
	input  wire [`REG_ADDR_BITS-1:0]  e_rd,
	input  wire [`XLEN-1:0]           e_result,
	input  wire [`XLEN-1:0]           e_next_pc,
	input  wire                       e_taken,
	input  wire                       e_illegal,
	output logic                      wb_valid,
	output logic [`REG_ADDR_BITS-1:0] wb_rd,
	output logic [`XLEN-1:0]          wb_data,
	output logic [`XLEN-1:0]          next_pc,
	output logic                      branch_taken,
	output logic                      illegal,
	output logic                      wr_en,
	output logic [`REG_ADDR_BITS-1:0] wr_addr,
	output logic [`XLEN-1:0]          wr_data
);

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_valid     <= 1'b0;
			branch_taken <= 1'b0;
			illegal      <= 1'b0;
		end else begin
			wb_valid     <= e_valid;
			branch_taken <= e_taken;
			illegal      <= e_illegal;
		end
	end

	always_ff @(posedge clk) begin
		wb_rd   <= e_rd;
		wb_data <= e_result;
		next_pc <= e_next_pc;
	end

	// register file takes the write on the edge after wb_valid rises
	assign wr_en   = wb_valid && !illegal && wb_rd != '0;
	assign wr_addr = wb_rd;
	assign wr_data = wb_data;

endmodule

`default_nettype wire

/* rv_int_unit.sv */
/* top of the rv32i integer path: decode, execute and result stages
   around the register file; one instruction may enter per cycle */
`timescale 1ns/1ps
`default_nettype none
`include "rv_int_consts.svh"

module rv_int_unit
	import rv_int_pkg::*;
(
	input  wire                       clk,
	input  wire                       reset,
	input  wire                       instr_valid,
	input  wire [31:0]                instr,
	input  wire [`XLEN-1:0]           pc,
	output logic                      wb_valid,
	output logic [`REG_ADDR_BITS-1:0] wb_rd,
	output logic [`XLEN-1:0]          wb_data,
	output logic [`XLEN-1:0]          next_pc,
	output logic                      branch_taken,
	output logic                      illegal
);

	// register file ports
	logic [`REG_ADDR_BITS-1:0] rs1_addr;
	logic [`REG_ADDR_BITS-1:0] rs2_addr;
	logic [`XLEN-1:0]          rs1_data;
	logic [`XLEN-1:0]          rs2_data;
	logic                      wr_en;
	logic [`REG_ADDR_BITS-1:0] wr_addr;
	logic [`XLEN-1:0]          wr_data;

	// decode to execute
	logic                      d_valid;
	logic [`REG_ADDR_BITS-1:0] d_rs1;
	logic [`REG_ADDR_BITS-1:0] d_rs2;
	logic [`REG_ADDR_BITS-1:0] d_rd;
	logic [`XLEN-1:0]          d_rs1_data;
	logic [`XLEN-1:0]          d_rs2_data;
	logic [`XLEN-1:0]          d_imm;
	logic [`XLEN-1:0]          d_pc;
	alu_op_t                   d_alu_op;
	logic                      d_use_imm;
	logic                      d_use_pc;
	branch_cond_t              d_branch;
	logic                      d_illegal;

	// execute to writeback
	logic                      e_valid;
	logic [`REG_ADDR_BITS-1:0] e_rd;
	logic [`XLEN-1:0]          e_result;
	logic [`XLEN-1:0]          e_next_pc;
	logic                      e_taken;
	logic                      e_illegal;

	rv_decoder u_decoder (
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (pc),
		.rs1_addr    (rs1_addr),
		.rs2_addr    (rs2_addr),
		.rs1_data    (rs1_data),
		.rs2_data    (rs2_data),
		.d_valid     (d_valid),
		.d_rs1       (d_rs1),
		.d_rs2       (d_rs2),
		.d_rd        (d_rd),
		.d_rs1_data  (d_rs1_data),
		.d_rs2_data  (d_rs2_data),
		.d_imm       (d_imm),
		.d_pc        (d_pc),
		.d_alu_op    (d_alu_op),
		.d_use_imm   (d_use_imm),
		.d_use_pc    (d_use_pc),
		.d_branch    (d_branch),
		.d_illegal   (d_illegal)
	);

	rv_reg_file u_reg_file (
		.clk      (clk),
		.reset    (reset),
		.rs1_addr (rs1_addr),
		.rs2_addr (rs2_addr),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data)
	);

	// forwarding taps come back from the writeback outputs
	rv_executor u_executor (
		.clk        (clk),
		.reset      (reset),
		.d_valid    (d_valid),
		.d_rs1      (d_rs1),
		.d_rs2      (d_rs2),
		.d_rd       (d_rd),
		.d_rs1_data (d_rs1_data),
		.d_rs2_data (d_rs2_data),
		.d_imm      (d_imm),
		.d_pc       (d_pc),
		.d_alu_op   (d_alu_op),
		.d_use_imm  (d_use_imm),
		.d_use_pc   (d_use_pc),
		.d_branch   (d_branch),
		.d_illegal  (d_illegal),
		.wb_valid   (wb_valid),
		.wb_rd      (wb_rd),
		.wb_data    (wb_data),
		.e_valid    (e_valid),
		.e_rd       (e_rd),
		.e_result   (e_result),
		.e_next_pc  (e_next_pc),
		.e_taken    (e_taken),
		.e_illegal  (e_illegal)
	);

	rv_writeback u_writeback (
		.clk          (clk),
		.reset        (reset),
		.e_valid      (e_valid),
		.e_rd         (e_rd),
		.e_result     (e_result),
		.e_next_pc    (e_next_pc),
		.e_taken      (e_taken),
		.e_illegal    (e_illegal),
		.wb_valid     (wb_valid),
		.wb_rd        (wb_rd),
		.wb_data      (wb_data),
		.next_pc      (next_pc),
		.branch_taken (branch_taken),
		.illegal      (illegal),
		.wr_en        (wr_en),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data)
	);

endmodule

`default_nettype wire

/* tb_rv_model.svh */
/* reference model for the integer path testbench, included in the testbench module
   holds the shadow register file and predicts each issued instruction in program order */
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

// architectural state as the program sees it
logic [`XLEN-1:0] shadow [`REG_COUNT] = '{default: '0};

// rv32i integer result by funct3, alt picks sub over add and sra over srl
function automatic logic [`XLEN-1:0] int_result(input logic [2:0] f3, input logic alt,
	input logic [`XLEN-1:0] x, input logic [`XLEN-1:0] y);
	case (f3)
		3'd0: int_result = alt ? x - y : x + y;
		3'd1: int_result = x << y[4:0];
		3'd2: int_result = ($signed(x) < $signed(y)) ? 1 : 0;
		3'd3: int_result = (x < y) ? 1 : 0;
		3'd4: int_result = x ^ y;
		3'd5: begin
			if (alt)
				int_result = $signed(x) >>> y[4:0];
			else
				int_result = x >> y[4:0];
		end
		3'd6: int_result = x | y;
		default: int_result = x & y;
	endcase
endfunction

// expected outcome of one word, commits its write to the shadow registers
function automatic void predict(input logic [31:0] word, input logic [`XLEN-1:0] at_pc,
	output logic [4:0] rd, output logic [`XLEN-1:0] data, output logic [`XLEN-1:0] npc,
	output logic taken, output logic bad);
	logic [`XLEN-1:0] a;
	logic [`XLEN-1:0] b;
	logic [`XLEN-1:0] imm_i;
	logic [`XLEN-1:0] imm_b;
	logic [`XLEN-1:0] imm_j;
	logic [2:0]       f3;
	logic [6:0]       f7;
	a = shadow[word[19:15]];
	b = shadow[word[24:20]];
	f3 = word[14:12];
	f7 = word[31:25];
	imm_i = {{20{word[31]}}, word[31:20]};
	imm_b = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
	imm_j = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
	rd = word[11:7];
	data = '0;
	npc = at_pc + 4;
	taken = 1'b0;
	bad = 1'b0;
	case (word[6:0])
		lui: data = {word[31:12], 12'b0};
		auipc: data = at_pc + {word[31:12], 12'b0};
		jal: begin
			data = at_pc + 4;
			npc = at_pc + imm_j;
			taken = 1'b1;
		end
		// link pc + 4, target lands on an even address
		jalr: begin
			bad = (f3 != 3'b000);
			data = at_pc + 4;
			npc = (a + imm_i) & ~32'h1;
			taken = 1'b1;
		end
		branch: begin
			rd = '0;
			case (f3)
				3'b000: taken = (a == b);
				3'b001: taken = (a != b);
				3'b100: taken = ($signed(a) < $signed(b));
				3'b101: taken = ($signed(a) >= $signed(b));
				3'b110: taken = (a < b);
				3'b111: taken = (a >= b);
				default: bad = 1'b1;
			endcase
			if (taken)
				npc = at_pc + imm_b;
		end
		op_imm: begin
			bad = (f3 == 3'b001 && f7 != 7'h00) ||
				(f3 == 3'b101 && f7 != 7'h00 && f7 != 7'h20);
			data = int_result(f3, f3 == 3'b101 && f7[5], a, imm_i);
		end
		op: begin
			bad = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)));
			data = int_result(f3, f7[5], a, b);
		end
		default: bad = 1'b1;
	endcase
	// illegal words report nothing and fall through to pc + 4
	if (bad) begin
		rd = '0;
		data = '0;
		npc = at_pc + 4;
		taken = 1'b0;
	end
	// x0 keeps zero, its result is still reported
	if (rd != 0)
		shadow[rd] = data;
endfunction

`endif

/* tb_rv_int_unit.sv */
/* testbench for rv_int_unit: issues rv32i integer instructions back to back
   and checks every result pulse against the model in tb_rv_model.svh */
`timescale 1ns/1ps
`default_nettype none
`include "rv_int_consts.svh"

module tb_rv_int_unit
	import rv_int_pkg::*;
();

	localparam int RESULT_TIMEOUT = 16;
	localparam int DRAIN_TIMEOUT  = 32;

	// one expected result, cycle is the counter value when the word was driven
	typedef struct packed {
		logic [4:0]  rd;
		logic [31:0] data;
		logic [31:0] npc;
		logic        taken;
		logic        bad;
		logic [31:0] cycle;
	} expect_t;

	logic                      clk;
	logic                      reset;
	logic                      instr_valid;
	logic [31:0]               instr;
	logic [`XLEN-1:0]          pc;
	logic                      wb_valid;
	logic [`REG_ADDR_BITS-1:0] wb_rd;
	logic [`XLEN-1:0]          wb_data;
	logic [`XLEN-1:0]          next_pc;
	logic                      branch_taken;
	logic                      illegal;

	integer           seed = 77522;
	int               cycle = 0;
	logic [`XLEN-1:0] cur_pc;
	expect_t          exp_q [$];

	// operand corners and branch compare pairs
	logic [31:0] corners [5] = '{32'h0, 32'h1, 32'h7fffffff, 32'h80000000, 32'hffffffff};
	logic [31:0] pair_a [6] = '{32'd5, 32'd3, 32'd7, 32'hffffffff, 32'd1, 32'h80000000};
	logic [31:0] pair_b [6] = '{32'd5, 32'd7, 32'd3, 32'd1, 32'hffffffff, 32'h7fffffff};
	logic [2:0]  br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

	`include "tb_rv_model.svh"

	rv_int_unit u_rv_int_unit (
		.clk          (clk),
		.reset        (reset),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.pc           (pc),
		.wb_valid     (wb_valid),
		.wb_rd        (wb_rd),
		.wb_data      (wb_data),
		.next_pc      (next_pc),
		.branch_taken (branch_taken),
		.illegal      (illegal)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	// instruction encoders
	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
		input logic [6:0] opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], branch};
	endfunction

	function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, jal};
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] want);
		if (got !== want)
			abort_run($sformatf("ERR %0t: %s is %h, expected %h", $time, what, got, want));
	endtask

	// drive one word on the falling edge and queue what the model expects
	task automatic issue(input logic [31:0] word);
		expect_t e;
		@(negedge clk);
		predict(word, cur_pc, e.rd, e.data, e.npc, e.taken, e.bad);
		e.cycle = cycle;
		exp_q.push_back(e);
		instr_valid = 1'b1;
		instr = word;
		pc = cur_pc;
		cur_pc = e.npc;
	endtask

	task automatic quiet(input int n);
		repeat (n) begin
			@(negedge clk);
			instr_valid = 1'b0;
		end
	endtask

	// lui plus addi, the addi depends on the lui at distance 1
	task automatic load_reg(input logic [4:0] r, input logic [31:0] v);
		logic [31:0] up;
		up = v + 32'h800;
		issue(enc_u(up[31:12], r, lui));
		issue(enc_i(v[11:0], r, 3'b000, r, op_imm));
	endtask

	// compare process, one result per wb_valid cycle
	always @(negedge clk) begin : monitor
		expect_t e;
		if (!reset) begin
			if (wb_valid) begin
				if (exp_q.size() == 0) begin
					abort_run("wb_valid pulsed with no instruction in flight");
				end else begin
					e = exp_q.pop_front();
					check("wb_valid latency", cycle - e.cycle, 3);
					check("wb_rd", wb_rd, e.rd);
					check("wb_data", wb_data, e.data);
					check("next_pc", next_pc, e.npc);
					check("branch_taken", branch_taken, e.taken);
					check("illegal", illegal, e.bad);
				end
			end else if (exp_q.size() != 0 && cycle - exp_q[0].cycle > RESULT_TIMEOUT) begin
				abort_run("no result arrived on wb_valid within the timeout");
			end
		end
	end

	initial begin : stimulus
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] w;
		int          waited;
		clk = 1'b0;
		reset = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		pc = '0;
		cur_pc = 32'h0000_1000;
		// three rising edges with reset high
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check("wb_valid after reset", wb_valid, 0);
		check("branch_taken after reset", branch_taken, 0);
		check("illegal after reset", illegal, 0);

		// untouched registers read zero
		issue(enc_r(7'h00, 5'd31, 5'd20, 3'b110, 5'd3, op));

		// every op and op-imm, corners first then random operands
		for (int i = 0; i < 24; i++) begin
			if (i < 5) begin
				a = corners[i];
				b = corners[(i + 3) % 5];
			end else begin
				a = $random(seed);
				b = $random(seed);
			end
			load_reg(5'd1, a);
			load_reg(5'd2, b);
			for (int f = 0; f < 8; f++) begin
				issue(enc_r(7'h00, 5'd2, 5'd1, 3'(f), 5'd3, op));
				w = $random(seed);
				if (f == 1 || f == 5)
					w[11:5] = 7'h00;
				issue(enc_i(w[11:0], 5'd1, 3'(f), 5'd4, op_imm));
			end
			issue(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd3, op));
			issue(enc_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd3, op));
			issue(enc_i({7'h20, b[4:0]}, 5'd1, 3'b101, 5'd4, op_imm));
		end

		// upper immediates and jumps, jalr sums are odd
		for (int i = 0; i < 8; i++) begin
			w = $random(seed);
			issue(enc_u(w[31:12], 5'd5, lui));
			issue(enc_u(w[19:0], 5'd6, auipc));
			w = $random(seed);
			issue(enc_j({w[20:1], 1'b0}, 5'd7));
			load_reg(5'd8, $random(seed) | 1);
			issue(enc_i({w[11:1], 1'b0}, 5'd8, 3'b000, 5'd9, jalr));
		end

		// six branch conditions on equal, less and greater pairs
		for (int p = 0; p < 6; p++) begin
			load_reg(5'd10, pair_a[p]);
			load_reg(5'd11, pair_b[p]);
			for (int k = 0; k < 6; k++) begin
				w = $random(seed);
				issue(enc_b({w[12:1], 1'b0}, 5'd11, 5'd10, br_f3[k]));
			end
		end

		// consumer at distance 1 to 4 from its producer
		for (int d = 1; d <= 4; d++) begin
			load_reg(5'd12, $random(seed));
			for (int k = 1; k < d; k++)
				issue(enc_i(12'(k), 5'd0, 3'b000, 5'd13, op_imm));
			issue(enc_r(7'h00, 5'd12, 5'd12, 3'b000, 5'd14, op));
			quiet(4);
		end
		for (int k = 0; k < 6; k++)
			issue(enc_i(12'h001, 5'd15, 3'b000, 5'd15, op_imm));
		issue(enc_r(7'h20, 5'd15, 5'd0, 3'b000, 5'd16, op));

		// writes to x0 vanish, also while they are in flight
		issue(enc_i(12'h07b, 5'd1, 3'b000, 5'd0, op_imm));
		issue(enc_u(20'habcde, 5'd0, lui));
		issue(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd17, op));
		issue(enc_r(7'h00, 5'd0, 5'd1, 3'b110, 5'd18, op));
		quiet(4);
		issue(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd19, op));

		// illegal words leave x20 alone
		load_reg(5'd20, 32'h1234_5678);
		issue(32'hffff_ffff);
		issue(enc_i(12'h010, 5'd20, 3'b010, 5'd20, 7'b0000011));
		issue(enc_r(7'h01, 5'd20, 5'd20, 3'b000, 5'd20, op));
		issue(enc_r(7'h20, 5'd20, 5'd20, 3'b001, 5'd20, op));
		issue(enc_i({7'h10, 5'd3}, 5'd20, 3'b001, 5'd20, op_imm));
		issue(enc_i({7'h10, 5'd3}, 5'd20, 3'b101, 5'd20, op_imm));
		issue(enc_i(12'h000, 5'd20, 3'b001, 5'd20, jalr));
		issue(enc_b(13'h010, 5'd20, 5'd20, 3'b010));
		issue(enc_r(7'h00, 5'd0, 5'd20, 3'b000, 5'd21, op));

		// random stream over x0..x7 with the odd bubble
		for (int i = 0; i < 150; i++) begin
			w = $random(seed);
			if (w[31:29] == 3'b000)
				quiet(1);
			if (w[0])
				issue(enc_r((w[1] && (w[4:2] == 3'd0 || w[4:2] == 3'd5)) ? 7'h20 : 7'h00,
					{2'b0, w[7:5]}, {2'b0, w[10:8]}, w[4:2], {2'b0, w[13:11]}, op));
			else if (w[4:2] == 3'd1 || w[4:2] == 3'd5)
				issue(enc_i({1'b0, w[1], 5'b0, w[18:14]}, {2'b0, w[10:8]}, w[4:2],
					{2'b0, w[13:11]}, op_imm));
			else
				issue(enc_i(w[25:14], {2'b0, w[10:8]}, w[4:2], {2'b0, w[13:11]}, op_imm));
		end

		// let the pipe drain
		quiet(1);
		waited = 0;
		while (exp_q.size() != 0) begin
			if (waited >= DRAIN_TIMEOUT) begin
				abort_run("results still outstanding after the drain timeout");
			end else begin
				@(posedge clk);
				waited++;
			end
		end
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

/* rv_int_unit.f */
+incdir+.
rv_int_pkg.sv
rv_reg_file.sv
rv_decoder.sv
rv_alu.sv
rv_executor.sv
rv_writeback.sv
rv_int_unit.sv
tb_rv_int_unit.sv

/* Bender.yml */
package:
  name: rv_int_unit

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - rv_int_pkg.sv
      - rv_reg_file.sv
      - rv_decoder.sv
      - rv_alu.sv
      - rv_executor.sv
      - rv_writeback.sv
      - rv_int_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_rv_int_unit.sv
